//--- design/flash_rd_pkg.sv
/*
  Shared definitions of the flash read pipeline
  - address and data widths with their vector types
  - read buffer state encoding
  - buffer, response order and flash operation structs
*/

package flash_rd_pkg;

  // a bus word is half a flash word, so the bus address has one more bit
  localparam int BusAddrW   = 12;
  localparam int WordAddrW  = 11;
  localparam int PageW      = 5;
  localparam int WordW      = 6;
  localparam int BufIdxW    = 3;
  localparam int FlashDataW = 64;
  localparam int BusDataW   = 32;

  typedef logic [BusAddrW-1:0]   bus_addr_t;
  typedef logic [WordAddrW-1:0]  word_addr_t;
  typedef logic [BufIdxW-1:0]    buf_idx_t;
  typedef logic [FlashDataW-1:0] flash_data_t;
  typedef logic [BusDataW-1:0]   bus_data_t;

  // a buffer is allocated into BufWip and turns BufValid when its data lands
  typedef enum logic [1:0] {
    BufInvalid = 2'd0,
    BufWip     = 2'd1,
    BufValid   = 2'd2
  } buf_state_e;

  typedef struct packed {
    buf_state_e  state;
    word_addr_t  addr;
    flash_data_t data;
  } rd_buf_t;

  // one entry per accepted read, naming the data source and the bus half
  typedef struct packed {
    buf_idx_t buf_idx;
    logic     word_sel;
  } rsp_entry_t;

  typedef struct packed {
    logic prog;
    logic pg_erase;
    logic bk_erase;
  } flash_op_t;

endpackage

//--- design/flash_rd_buf.sv
/*
  Single read buffer entry
  - state machine over invalid, work in progress and valid
  - stored flash word address and flash data
*/

module flash_rd_buf
  import flash_rd_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        en_i,
  input  logic        alloc_i,
  input  logic        update_i,
  input  logic        wipe_i,
  input  word_addr_t  addr_i,
  input  flash_data_t data_i,
  output rd_buf_t     buf_o
);

  buf_state_e  state_q, state_d;
  word_addr_t  addr_q;
  flash_data_t data_q;

  // a valid entry can be taken over by a new allocation
  // while a work in progress entry only waits for its flash data
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      BufInvalid: begin
        if (alloc_i) begin
          state_d = BufWip;
        end
      end
      BufWip: begin
        if (update_i) begin
          state_d = BufValid;
        end
      end
      BufValid: begin
        if (alloc_i) begin
          state_d = BufWip;
        end
      end
      default: state_d = BufInvalid;
    endcase
    // a hazard flush or a disabled buffer always wins
    if (!en_i || wipe_i) begin
      state_d = BufInvalid;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= BufInvalid;
    end else begin
      state_q <= state_d;
    end
  end

  // the address is captured at allocation and the data at update
  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      addr_q <= addr_i;
    end
    if (update_i) begin
      data_q <= data_i;
    end
  end

  assign buf_o.state = state_q;
  assign buf_o.addr  = addr_q;
  assign buf_o.data  = data_q;

endmodule

//--- design/flash_rd_buf_dep.sv
/*
  Buffer dependency tracking
  - one counter per buffer of responses still queued for it
  - dependency flags and the all-blocked indication
*/

module flash_rd_buf_dep
  import flash_rd_pkg::*;
#(
  parameter int NumBuf   = 4,
  parameter int RspDepth = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              en_i,
  input  logic              wr_i,
  input  logic              rd_i,
  input  buf_idx_t          wr_idx_i,
  input  buf_idx_t          rd_idx_i,
  output logic [NumBuf-1:0] dep_o,
  output logic              all_dep_o
);

  // a counter must hold every entry the response FIFO can hold
  localparam int CntW = $clog2(RspDepth + 1);

  typedef logic [CntW-1:0] cnt_t;

  cnt_t cnt_q [NumBuf];

  for (genvar i = 0; i < NumBuf; i++) begin : gen_cnt
    logic inc;
    logic dec;

    // nothing is tracked while the buffers are off, as the FIFO is empty at every switch
    assign inc = en_i & wr_i & (wr_idx_i == buf_idx_t'(i));
    assign dec = en_i & rd_i & (rd_idx_i == buf_idx_t'(i));

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[i] <= '0;
      end else if (inc && !dec) begin
        cnt_q[i] <= cnt_q[i] + cnt_t'(1);
      end else if (dec && !inc) begin
        cnt_q[i] <= cnt_q[i] - cnt_t'(1);
      end
    end

    // a buffer with queued responses must keep its contents
    assign dep_o[i] = cnt_q[i] != '0;
  end

  assign all_dep_o = &dep_o;

endmodule

//--- design/flash_rd_rsp_fifo.sv
/*
  Response order FIFO
  - holds buffer index and word select per accepted read
  - synchronous, with pointers and an entry count
*/

module flash_rd_rsp_fifo
  import flash_rd_pkg::*;
#(
  parameter int RspDepth = 4
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       wr_i,
  input  rsp_entry_t wdata_i,
  input  logic       rd_i,
  output logic       full_o,
  output logic       empty_o,
  output rsp_entry_t rdata_o
);

  localparam int PtrW = (RspDepth > 1) ? $clog2(RspDepth) : 1;
  localparam int CntW = $clog2(RspDepth + 1);

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [CntW-1:0] cnt_t;

  rsp_entry_t mem_q [RspDepth];
  ptr_t       wr_ptr_q;
  ptr_t       rd_ptr_q;
  cnt_t       cnt_q;
  logic       push;
  logic       pop;

  assign push = wr_i & ~full_o;
  assign pop  = rd_i & ~empty_o;

  //////////////////////////////////////////////////////////////////////////
  // pointers and count
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(RspDepth - 1)) ? '0 : wr_ptr_q + ptr_t'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(RspDepth - 1)) ? '0 : rd_ptr_q + ptr_t'(1);
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + cnt_t'(1);
      end else if (pop && !push) begin
        cnt_q <= cnt_q - cnt_t'(1);
      end
    end
  end

  // the entry storage is written at the write pointer
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  assign rdata_o = mem_q[rd_ptr_q];
  assign full_o  = cnt_q == cnt_t'(RspDepth);
  assign empty_o = cnt_q == '0;

endmodule

//--- design/flash_rd_alloc.sv
/*
  Read buffer allocation
  - hit matching of a read against the buffers
  - hazard flushing on program and erase
  - choice of the buffer to allocate on a miss
*/

module flash_rd_alloc
  import flash_rd_pkg::*;
#(
  parameter int NumBuf = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  logic              en_i,
  input  bus_addr_t         addr_i,
  input  flash_op_t         op_i,
  input  rd_buf_t           bufs_i [NumBuf],
  input  logic [NumBuf-1:0] dep_i,
  input  logic              take_i,
  output logic [NumBuf-1:0] hit_o,
  output logic [NumBuf-1:0] alloc_o,
  output logic [NumBuf-1:0] flush_o
);

  word_addr_t        word_addr;
  logic [NumBuf-1:0] buf_valid;
  logic [NumBuf-1:0] buf_wip;
  logic [NumBuf-1:0] buf_invalid;
  logic [NumBuf-1:0] inv_alloc;
  logic [NumBuf-1:0] rr_cand;
  logic [NumBuf-1:0] rr_alloc;
  logic [NumBuf-1:0] choice;
  buf_idx_t          rr_q;
  buf_idx_t          rr_pick;
  logic              rr_found;

  // the lower bus address bit only selects the half of the flash word
  assign word_addr = addr_i[BusAddrW-1:1];

  for (genvar i = 0; i < NumBuf; i++) begin : gen_state
    assign buf_valid[i]   = bufs_i[i].state == BufValid;
    assign buf_wip[i]     = bufs_i[i].state == BufWip;
    assign buf_invalid[i] = bufs_i[i].state == BufInvalid;
  end

  //////////////////////////////////////////////////////////////////////////
  // hits and hazards
  //////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NumBuf; i++) begin : gen_match
    logic word_match;
    logic page_match;

    assign word_match = bufs_i[i].addr == word_addr;
    // both sides are flash word addresses here, so the page sits above WordW
    assign page_match = bufs_i[i].addr[WordW +: PageW] == word_addr[WordW +: PageW];

    // a work in progress buffer also hits and its response waits for the data
    assign hit_o[i] = req_i & en_i & (buf_valid[i] | buf_wip[i]) & word_match;

    // operations only arrive while idle, so no buffer is in progress then
    assign flush_o[i] = buf_valid[i] &
                        (op_i.bk_erase |
                         (op_i.prog & word_match) |
                         (op_i.pg_erase & page_match));
  end

  //////////////////////////////////////////////////////////////////////////
  // replacement choice
  //////////////////////////////////////////////////////////////////////////

  // lowest invalid buffer first
  always_comb begin
    inv_alloc = '0;
    for (int i = 0; i < NumBuf; i++) begin
      if (buf_invalid[i] && inv_alloc == '0) begin
        inv_alloc[i] = 1'b1;
      end
    end
  end

  // Valid buffers still owed a response are never replaced, and a buffer in
  // progress always has its own response queued, so it never shows up here.
  assign rr_cand = buf_valid & ~dep_i;

  // search the candidates starting at the rotating pointer
  always_comb begin
    int unsigned idx;
    idx      = 0;
    rr_alloc = '0;
    rr_found = 1'b0;
    rr_pick  = rr_q;
    for (int k = 0; k < NumBuf; k++) begin
      idx = (int'(rr_q) + k) % NumBuf;
      if (!rr_found && rr_cand[idx]) begin
        rr_alloc[idx] = 1'b1;
        rr_found      = 1'b1;
        rr_pick       = buf_idx_t'(idx);
      end
    end
  end

  // the pointer moves past a buffer once it has really been taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (take_i && inv_alloc == '0 && rr_found) begin
      rr_q <= (rr_pick == buf_idx_t'(NumBuf - 1)) ? '0 : rr_pick + buf_idx_t'(1);
    end
  end

  assign choice = (inv_alloc != '0) ? inv_alloc : rr_alloc;

  // only a buffered miss allocates and nothing is kept while the buffers are off
  assign alloc_o = (req_i && en_i && hit_o == '0) ? choice : '0;

endmodule

//--- design/flash_rd_top.sv
/*
  Flash read pipeline top level
  - buffer enable, read stage and request acceptance
  - read buffers, allocation, dependency tracking, response order
  - response selection between flash data and buffer data
*/

module flash_rd_top
  import flash_rd_pkg::*;
#(
  parameter int NumBuf   = 4,
  parameter int RspDepth = 4
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        buf_en_i,
  input  logic        req_i,
  input  bus_addr_t   addr_i,
  input  flash_op_t   op_i,
  output logic        rdy_o,
  output logic        data_valid_o,
  output bus_data_t   data_o,
  output logic        idle_o,
  output logic        req_o,
  output word_addr_t  flash_addr_o,
  input  logic        ack_i,
  input  logic        done_i,
  input  flash_data_t data_i
);

  logic              buf_en_q;
  logic              no_en_chg;
  word_addr_t        word_addr;
  rd_buf_t           bufs [NumBuf];
  logic [NumBuf-1:0] hit, alloc, flush, update, dep;
  logic              all_dep, miss;
  logic              rd_busy, rd_start, rd_done, flash_rdy;
  logic [NumBuf-1:0] alloc_q;
  logic              fifo_wr, fifo_full, fifo_empty;
  rsp_entry_t        fifo_wdata, fifo_rdata;
  logic              head_valid, head_pend, flash_match, buf_match;
  flash_data_t       head_data, rsp_word;

  assign word_addr    = addr_i[BusAddrW-1:1];
  assign flash_addr_o = word_addr;

  // the enable may only switch with no response outstanding
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_en_q <= 1'b0;
    end else if (idle_o) begin
      buf_en_q <= buf_en_i;
    end
  end
  assign no_en_chg = buf_en_q == buf_en_i;

  //////////////////////////////////////////////////////////////////////////
  // buffers and allocation
  //////////////////////////////////////////////////////////////////////////

  flash_rd_alloc #(.NumBuf(NumBuf)) u_alloc (
    .clk_i, .rst_ni, .req_i, .en_i(buf_en_q), .addr_i, .op_i, .bufs_i(bufs),
    .dep_i(dep), .take_i(rd_start), .hit_o(hit), .alloc_o(alloc), .flush_o(flush)
  );

  for (genvar i = 0; i < NumBuf; i++) begin : gen_buf
    flash_rd_buf u_buf (
      .clk_i, .rst_ni, .en_i(buf_en_q), .alloc_i(fifo_wr & alloc[i]),
      .update_i(update[i]), .wipe_i(flush[i]), .addr_i(word_addr), .data_i,
      .buf_o(bufs[i])
    );
  end

  //////////////////////////////////////////////////////////////////////////
  // read stage and acceptance
  //////////////////////////////////////////////////////////////////////////

  assign miss      = hit == '0;
  assign rd_start  = req_o & ack_i;
  assign rd_done   = rd_busy & done_i;
  // a finishing read frees the stage for a new one in the same cycle
  assign flash_rdy = ~rd_busy | rd_done;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_busy <= 1'b0;
      alloc_q <= '0;
    end else if (rd_start) begin
      rd_busy <= 1'b1;
      alloc_q <= alloc;
    end else if (rd_done) begin
      rd_busy <= 1'b0;
    end
  end
  assign update = {NumBuf{rd_done}} & alloc_q;

  // a miss is taken exactly when the flash takes its read
  assign req_o = req_i & miss & flash_rdy & ~fifo_full & ~all_dep & no_en_chg;
  assign rdy_o = (miss ? ack_i & flash_rdy : 1'b1) & ~fifo_full & ~all_dep & no_en_chg;
  assign fifo_wr = req_i & rdy_o;

  // the entry names the allocated buffer on a miss and the hit one otherwise
  always_comb begin
    fifo_wdata.buf_idx  = '0;
    fifo_wdata.word_sel = addr_i[0];
    for (int i = 0; i < NumBuf; i++) begin
      if (alloc[i] || hit[i]) begin
        fifo_wdata.buf_idx = buf_idx_t'(i);
      end
    end
  end

  flash_rd_rsp_fifo #(.RspDepth(RspDepth)) u_rsp_fifo (
    .clk_i, .rst_ni, .wr_i(fifo_wr), .wdata_i(fifo_wdata), .rd_i(data_valid_o),
    .full_o(fifo_full), .empty_o(fifo_empty), .rdata_o(fifo_rdata)
  );

  flash_rd_buf_dep #(.NumBuf(NumBuf), .RspDepth(RspDepth)) u_buf_dep (
    .clk_i, .rst_ni, .en_i(buf_en_q), .wr_i(fifo_wr), .rd_i(data_valid_o),
    .wr_idx_i(fifo_wdata.buf_idx), .rd_idx_i(fifo_rdata.buf_idx),
    .dep_o(dep), .all_dep_o(all_dep)
  );

  //////////////////////////////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    head_valid = 1'b0;
    head_pend  = 1'b0;
    head_data  = data_i;
    for (int i = 0; i < NumBuf; i++) begin
      if (fifo_rdata.buf_idx == buf_idx_t'(i)) begin
        head_valid = bufs[i].state == BufValid;
        head_pend  = alloc_q[i];
        head_data  = bufs[i].data;
      end
    end
  end

  // with the buffers off every entry is a plain flash read in order
  assign flash_match = ~fifo_empty & rd_done & (~buf_en_q | head_pend);
  assign buf_match   = ~fifo_empty & buf_en_q & head_valid;

  assign rsp_word     = flash_match ? data_i : head_data;
  assign data_o       = fifo_rdata.word_sel ? rsp_word[63:32] : rsp_word[31:0];
  assign data_valid_o = flash_match | buf_match;
  assign idle_o       = fifo_empty;

endmodule

//--- bench/flash_rd_flash_model.sv
/*
  Behavioral flash for the read pipeline testbench
  - word image with a version per word, bumped by program and erase
  - read port with random ack and done latency from an xorshift generator
  - count of flash reads taken
*/

module flash_rd_flash_model
  import flash_rd_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  input  word_addr_t  addr_i,
  input  flash_op_t   op_i,
  input  bus_addr_t   op_addr_i,
  output logic        ack_o,
  output logic        done_o,
  output flash_data_t data_o,
  output int unsigned acc_cnt_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          NumWords = 2 ** WordAddrW;
  localparam logic [31:0] Seed     = 32'h26eb_7667;

  flash_data_t mem_q [NumWords];
  logic [31:0] rng_q;
  int unsigned ack_wait_q;
  logic [1:0]  ack_dly_q;
  logic [1:0]  done_wait_q;
  logic        busy_q;
  word_addr_t  rd_addr_q;
  word_addr_t  op_word;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // the top byte holds the version and both halves carry the whole word address
  function automatic flash_data_t word_value(input word_addr_t a, input logic [7:0] ver);
    return {ver, 8'hA5, 5'h00, a, ~ver, 8'h5A, 5'h1F, ~a};
  endfunction

  assign op_word = op_addr_i[BusAddrW-1:1];

  // ack comes once the request has waited its drawn number of cycles
  assign ack_o  = req_i && (ack_wait_q >= ack_dly_q);
  assign done_o = busy_q && (done_wait_q == 2'd0);
  assign data_o = mem_q[rd_addr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int a = 0; a < NumWords; a++) begin
        mem_q[a] <= word_value(word_addr_t'(a), 8'h00);
      end
      rng_q       <= Seed;
      ack_wait_q  <= 0;
      ack_dly_q   <= Seed[1:0];
      done_wait_q <= 2'd0;
      busy_q      <= 1'b0;
      rd_addr_q   <= '0;
      acc_cnt_o   <= 0;
    end else begin
      if (req_i && ack_o) begin
        // done follows 1 to 4 cycles after the read is taken
        acc_cnt_o   <= acc_cnt_o + 1;
        busy_q      <= 1'b1;
        rd_addr_q   <= addr_i;
        done_wait_q <= rng_q[9:8];
        ack_dly_q   <= rng_q[1:0];
        ack_wait_q  <= 0;
        rng_q       <= xorshift32(rng_q);
      end else begin
        if (done_o) begin
          busy_q <= 1'b0;
        end else if (busy_q) begin
          done_wait_q <= done_wait_q - 2'd1;
        end
        ack_wait_q <= req_i ? ack_wait_q + 1 : 0;
      end
      // program and erase bump the version of every word they reach
      if (op_i != '0) begin
        for (int a = 0; a < NumWords; a++) begin
          if (op_i.bk_erase ||
              (op_i.prog && word_addr_t'(a) == op_word) ||
              (op_i.pg_erase && (word_addr_t'(a) >> WordW) == (op_word >> WordW))) begin
            mem_q[a] <= word_value(word_addr_t'(a), mem_q[a][63:56] + 8'h01);
          end
        end
      end
    end
  end

endmodule

//--- bench/flash_rd_tb.sv
/*
  Testbench of the flash read pipeline
  - clock, reset, behavioral flash and response monitor
  - read issue, drain and compare tasks
  - directed tests of hits, replacement, hazard flushes and disabled buffers
*/

module flash_rd_tb
  import flash_rd_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumBuf    = 4;
  localparam int RspDepth  = 4;
  localparam int WaitLimit = 200;
  localparam int RunLimit  = 50000;

  logic        clk_i;
  logic        rst_ni;
  logic        buf_en_i;
  logic        req_i;
  bus_addr_t   addr_i;
  flash_op_t   op_i;
  logic        rdy_o;
  logic        data_valid_o;
  bus_data_t   data_o;
  logic        idle_o;
  logic        req_o;
  word_addr_t  flash_addr_o;
  logic        ack_i;
  logic        done_i;
  flash_data_t data_i;
  int unsigned acc_cnt;

  int unsigned data_errs  = 0;
  int unsigned count_errs = 0;
  int unsigned wait_errs  = 0;
  int unsigned miss_cnt   = 0;
  bus_data_t   exp_q [$];
  bus_addr_t   rd_q [$];

  flash_rd_top #(.NumBuf(NumBuf), .RspDepth(RspDepth)) DUT (
    .clk_i, .rst_ni, .buf_en_i, .req_i, .addr_i, .op_i, .rdy_o, .data_valid_o,
    .data_o, .idle_o, .req_o, .flash_addr_o, .ack_i, .done_i, .data_i
  );

  flash_rd_flash_model u_flash (
    .clk_i, .rst_ni, .req_i(req_o), .addr_i(flash_addr_o), .op_i, .op_addr_i(addr_i),
    .ack_o(ack_i), .done_o(done_i), .data_o(data_i), .acc_cnt_o(acc_cnt)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // a run that stalls somewhere is stopped here
  initial begin
    repeat (RunLimit) @(posedge clk_i);
    $display("simulation ran past its cycle limit");
    $display("TESTBENCH FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks and response monitor
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_count(input string name, input int unsigned got,
                             input int unsigned exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      count_errs++;
    end
  endtask

  // the bus word is the half of the image word chosen by the lowest address bit
  function automatic bus_data_t expected_word(input bus_addr_t a);
    flash_data_t w;
    w = u_flash.mem_q[a[BusAddrW-1:1]];
    return a[0] ? w[63:32] : w[31:0];
  endfunction

  // responses are sampled mid cycle, where every output has settled
  always @(negedge clk_i) begin
    if (rst_ni && data_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("a response arrived with no read outstanding");
        data_errs++;
      end else begin
        check_data("data_o", data_o, exp_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus tasks that start and end on a rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic read_word(input bus_addr_t a);
    int unsigned t;
    logic        taken;
    t     = 0;
    taken = 1'b0;
    req_i  <= 1'b1;
    addr_i <= a;
    while (!taken && t < WaitLimit) begin
      @(negedge clk_i);
      // the read is taken at the coming edge, so the image is read now
      if (rdy_o) begin
        taken = 1'b1;
        exp_q.push_back(expected_word(a));
        if (req_o) begin
          miss_cnt++;
        end
      end
      @(posedge clk_i);
      t++;
    end
    if (!taken) begin
      $display("read of address %h was never accepted", a);
      wait_errs++;
      req_i <= 1'b0;
    end
  endtask

  task automatic wait_drain();
    int unsigned t;
    logic        drained;
    t       = 0;
    drained = 1'b0;
    while (!drained && t < WaitLimit) begin
      @(negedge clk_i);
      // the last read was taken at the edge before, so its entry is still queued
      if (t == 0 && idle_o) begin
        $display("idle_o was high while a read was still queued");
        wait_errs++;
      end
      drained = idle_o && exp_q.size() == 0;
      t++;
    end
    if (!drained) begin
      $display("responses did not drain, %0d still expected", exp_q.size());
      wait_errs++;
      exp_q.delete();
    end
    @(posedge clk_i);
  endtask

  // reads of the queued addresses go out back to back
  task automatic issue_burst();
    while (rd_q.size() > 0) begin
      read_word(rd_q.pop_front());
    end
    req_i <= 1'b0;
    wait_drain();
  endtask

  task automatic queue_word(input word_addr_t w, input logic half);
    rd_q.push_back({w, half});
  endtask

  // operations are single cycle strobes given while the pipeline is idle
  task automatic apply_op(input flash_op_t op, input word_addr_t w);
    op_i   <= op;
    addr_i <= {w, 1'b0};
    @(posedge clk_i);
    op_i <= '0;
  endtask

  task automatic set_enable(input logic en);
    buf_en_i <= en;
    repeat (2) @(posedge clk_i);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic single_word_both_halves();
    int unsigned c0;
    c0 = acc_cnt;
    queue_word(11'h123, 1'b0);
    queue_word(11'h123, 1'b1);
    issue_burst();
    check_count("flash accesses for one word", acc_cnt - c0, 1);
  endtask

  task automatic repeated_reads_hit();
    word_addr_t  words [NumBuf];
    int unsigned c0;
    words = '{11'h123, 11'h040, 11'h2a7, 11'h7f1};
    c0 = acc_cnt;
    for (int i = 0; i < NumBuf; i++) begin
      queue_word(words[i], 1'b0);
    end
    issue_burst();
    // the first word is still buffered from the previous test
    check_count("flash accesses of first pass", acc_cnt - c0, NumBuf - 1);
    c0 = acc_cnt;
    for (int p = 1; p < 3; p++) begin
      for (int i = 0; i < NumBuf; i++) begin
        queue_word(words[i], p[0]);
      end
    end
    issue_burst();
    check_count("flash accesses of later passes", acc_cnt - c0, 0);
  endtask

  task automatic replacement_under_latency();
    int unsigned c0;
    int unsigned m0;
    c0 = acc_cnt;
    m0 = miss_cnt;
    // each fresh word is read lower half first, so its upper half hits that buffer
    for (int i = 0; i < 3 * NumBuf; i++) begin
      queue_word(word_addr_t'(11'h500 + i * 19), 1'b0);
      queue_word(word_addr_t'(11'h500 + i * 19), 1'b1);
    end
    issue_burst();
    check_count("flash accesses of fresh words", acc_cnt - c0, 3 * NumBuf);
    check_count("accepted misses", miss_cnt - m0, acc_cnt - c0);
  endtask

  task automatic queue_hazard_set();
    queue_word(11'h0c5, 1'b0);
    queue_word(11'h0d0, 1'b1);
    queue_word(11'h305, 1'b0);
  endtask

  // 0c5 and 0d0 share page 3 and 305 sits in page 12
  task automatic program_erase_flush();
    flash_op_t   op;
    int unsigned c0;
    queue_hazard_set();
    issue_burst();
    c0 = acc_cnt;
    queue_hazard_set();
    issue_burst();
    check_count("flash accesses of buffered set", acc_cnt - c0, 0);
    op      = '0;
    op.prog = 1'b1;
    apply_op(op, 11'h0c5);
    c0 = acc_cnt;
    queue_hazard_set();
    issue_burst();
    check_count("flash accesses after program", acc_cnt - c0, 1);
    op          = '0;
    op.pg_erase = 1'b1;
    apply_op(op, 11'h0c5);
    c0 = acc_cnt;
    queue_hazard_set();
    issue_burst();
    check_count("flash accesses after page erase", acc_cnt - c0, 2);
    op          = '0;
    op.bk_erase = 1'b1;
    apply_op(op, 11'h305);
    c0 = acc_cnt;
    queue_hazard_set();
    issue_burst();
    check_count("flash accesses after bank erase", acc_cnt - c0, 3);
  endtask

  task automatic disabled_buffers_read();
    int unsigned c0;
    int unsigned m0;
    set_enable(1'b0);
    c0 = acc_cnt;
    m0 = miss_cnt;
    queue_word(11'h0c5, 1'b0);
    queue_word(11'h0c5, 1'b1);
    queue_word(11'h600, 1'b0);
    queue_word(11'h0c5, 1'b0);
    queue_word(11'h600, 1'b1);
    queue_word(11'h600, 1'b1);
    issue_burst();
    check_count("flash accesses with buffers off", acc_cnt - c0, 6);
    check_count("accepted misses with buffers off", miss_cnt - m0, 6);
  endtask

  initial begin
    rst_ni   = 1'b0;
    buf_en_i = 1'b1;
    req_i    = 1'b0;
    addr_i   = '0;
    op_i     = '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (4) @(posedge clk_i);

    single_word_both_halves();
    repeated_reads_hit();
    replacement_under_latency();
    program_erase_flush();
    disabled_buffers_read();

    $display("errors: data %0d, count %0d, wait %0d", data_errs, count_errs, wait_errs);
    if (data_errs + count_errs + wait_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
design/flash_rd_pkg.sv
design/flash_rd_buf.sv
design/flash_rd_buf_dep.sv
design/flash_rd_rsp_fifo.sv
design/flash_rd_alloc.sv
design/flash_rd_top.sv
bench/flash_rd_flash_model.sv
bench/flash_rd_tb.sv
